// File: rtl/fft_pkg.sv
`default_nettype none

package fft_pkg;

    // one component of a complex sample
    typedef logic signed [15:0] sample_t;

    localparam int N_POINTS_DEFAULT = 8;
    localparam int LOG2_N = 3;

    // index of a sample or of a bin
    typedef logic [LOG2_N-1:0] sample_idx_t;

    // eight 33-bit terms fit without overflow
    typedef logic signed [35:0] acc_t;

    localparam int TWIDDLE_FRAC = 14;
    typedef logic signed [15:0] twiddle_t;

    // cos and sin of 2*pi*m/8 in Q1.14
    localparam twiddle_t COS_TABLE [N_POINTS_DEFAULT] = '{
        16'sd16384, 16'sd11585, 16'sd0, -16'sd11585,
        -16'sd16384, -16'sd11585, 16'sd0, 16'sd11585
    };

    localparam twiddle_t SIN_TABLE [N_POINTS_DEFAULT] = '{
        16'sd0, 16'sd11585, 16'sd16384, 16'sd11585,
        16'sd0, -16'sd11585, -16'sd16384, -16'sd11585
    };

    typedef enum logic [1:0] {
        ctrl_idle,
        ctrl_accumulate,
        ctrl_settle,
        ctrl_wait_read
    } ctrl_state_t;

    typedef enum logic [1:0] {
        buf_idle,
        buf_ack,
        buf_hold_last,
        buf_full
    } buf_state_t;

endpackage

`default_nettype wire

// File: rtl/sample_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module sample_buffer
    import fft_pkg::*;
#(
    parameter int N_POINTS = N_POINTS_DEFAULT
) (
    input  wire              osc_50,
    input  wire              reset_50m,
    input  wire              fft_send_command,
    input  wire              fft_inverse_in,
    input  wire sample_t     fft_data_real_in,
    input  wire sample_t     fft_data_imag_in,
    input  wire              fft_data_end_in,
    input  wire sample_idx_t rd_index,
    input  wire              result_valid,
    input  wire              block_done,
    output logic             fft_send_response,
    output logic             block_ready,
    output logic             inverse,
    output sample_t          rd_real,
    output sample_t          rd_imag
);

    localparam int COUNT_W = $clog2(N_POINTS + 1);

    buf_state_t         state;
    logic [COUNT_W-1:0] count;
    sample_t            mem_real [N_POINTS];
    sample_t            mem_imag [N_POINTS];
    logic               take_sample;
    logic               last_sample;

    // samples are only taken in idle, a full buffer leaves the command hanging
    assign take_sample = (state == buf_idle) && fft_send_command;
    assign last_sample = (count == COUNT_W'(N_POINTS - 1)) || fft_data_end_in;

    always_ff @(posedge osc_50) begin
        if (take_sample) begin
            mem_real[sample_idx_t'(count)] <= fft_data_real_in;
            mem_imag[sample_idx_t'(count)] <= fft_data_imag_in;
        end
    end

    // entries past the write count read as zero, which pads short blocks
    assign rd_real = (COUNT_W'(rd_index) < count) ? mem_real[rd_index] : '0;
    assign rd_imag = (COUNT_W'(rd_index) < count) ? mem_imag[rd_index] : '0;

    always_ff @(posedge osc_50) begin
        if (reset_50m) begin
            state             <= buf_idle;
            count             <= '0;
            fft_send_response <= 1'b0;
            block_ready       <= 1'b0;
            inverse           <= 1'b0;
        end else begin
            case (state)
                buf_idle: begin
                    if (take_sample) begin
                        count <= count + 1'b1;
                        // direction comes from the first sample of a block
                        if (count == '0) begin
                            inverse <= fft_inverse_in;
                        end
                        if (last_sample) begin
                            block_ready <= 1'b1;
                            state       <= buf_hold_last;
                        end else begin
                            fft_send_response <= 1'b1;
                            state             <= buf_ack;
                        end
                    end
                end
                buf_ack: begin
                    if (!fft_send_command) begin
                        fft_send_response <= 1'b0;
                        state             <= buf_idle;
                    end
                end
                // final ack waits for the first result
                buf_hold_last: begin
                    if (result_valid) begin
                        fft_send_response <= 1'b1;
                        state             <= buf_full;
                    end
                end
                buf_full: begin
                    if (!fft_send_command) begin
                        fft_send_response <= 1'b0;
                    end
                    if (block_done) begin
                        count       <= '0;
                        block_ready <= 1'b0;
                        // a final ack still up finishes its handshake first
                        state       <= fft_send_response ? buf_ack : buf_idle;
                    end
                end
                default: state <= buf_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/transform_control.sv
`timescale 1ns/1ns
`default_nettype none

module transform_control
    import fft_pkg::*;
#(
    parameter int N_POINTS = N_POINTS_DEFAULT
) (
    input  wire      osc_50,
    input  wire      reset_50m,
    input  wire      block_ready,
    input  wire      result_taken,
    output sample_idx_t rd_index,
    output sample_idx_t twiddle_index,
    output logic     acc_clear,
    output logic     acc_en,
    output logic     bin_done,
    output logic     last_bin,
    output logic     block_done
);

    ctrl_state_t state;
    sample_idx_t n;
    sample_idx_t k;
    logic        last_sample;
    logic        next_bin;

    assign last_sample = (n == sample_idx_t'(N_POINTS - 1));
    assign last_bin    = (k == sample_idx_t'(N_POINTS - 1));
    assign next_bin    = (state == ctrl_wait_read) && result_taken && !last_bin;

    assign rd_index      = n;
    assign twiddle_index = sample_idx_t'((int'(n) * int'(k)) % N_POINTS);

    // clear on the cycle before the first accumulate of each bin
    assign acc_clear  = ((state == ctrl_idle) && block_ready) || next_bin;
    assign acc_en     = (state == ctrl_accumulate);
    assign bin_done   = (state == ctrl_settle);
    assign block_done = (state == ctrl_wait_read) && result_taken && last_bin;

    always_ff @(posedge osc_50) begin
        if (reset_50m) begin
            state <= ctrl_idle;
            n     <= '0;
            k     <= '0;
        end else begin
            case (state)
                ctrl_idle: begin
                    if (block_ready) begin
                        n     <= '0;
                        k     <= '0;
                        state <= ctrl_accumulate;
                    end
                end
                ctrl_accumulate: begin
                    if (last_sample) begin
                        state <= ctrl_settle;
                    end else begin
                        n <= n + 1'b1;
                    end
                end
                // sums are final here, output stage latches them
                ctrl_settle: begin
                    n     <= '0;
                    state <= ctrl_wait_read;
                end
                // hold until the processor has taken the bin
                ctrl_wait_read: begin
                    if (block_done) begin
                        state <= ctrl_idle;
                    end else if (next_bin) begin
                        k     <= k + 1'b1;
                        state <= ctrl_accumulate;
                    end
                end
                default: state <= ctrl_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/dft_accumulator.sv
`timescale 1ns/1ns
`default_nettype none

module dft_accumulator
    import fft_pkg::*;
#(
    parameter int N_POINTS  = N_POINTS_DEFAULT,
    parameter int IMAG_PART = 0
) (
    input  wire              osc_50,
    input  wire              acc_clear,
    input  wire              acc_en,
    input  wire              inverse,
    input  wire sample_idx_t twiddle_index,
    input  wire sample_t     sample_real,
    input  wire sample_t     sample_imag,
    output acc_t             sum
);

    // a longer table is walked with a coarser step
    localparam int TABLE_STEP = $size(COS_TABLE) / N_POINTS;

    twiddle_t           cos_w;
    twiddle_t           sin_w;
    sample_t            cos_in;
    sample_t            sin_in;
    logic signed [31:0] cos_prod;
    logic signed [31:0] sin_prod;
    logic               neg_sin;
    acc_t               term;

    assign cos_w = COS_TABLE[int'(twiddle_index) * TABLE_STEP];
    assign sin_w = SIN_TABLE[int'(twiddle_index) * TABLE_STEP];

    // real part: xr*cos + xi*sin, imag part: xi*cos - xr*sin
    assign cos_in = (IMAG_PART != 0) ? sample_imag : sample_real;
    assign sin_in = (IMAG_PART != 0) ? sample_real : sample_imag;

    assign cos_prod = cos_in * cos_w;
    assign sin_prod = sin_in * sin_w;

    // inverse flips the sin term in both parts
    assign neg_sin = inverse ^ (IMAG_PART != 0);

    assign term = neg_sin ? acc_t'(cos_prod) - acc_t'(sin_prod)
                          : acc_t'(cos_prod) + acc_t'(sin_prod);

    always_ff @(posedge osc_50) begin
        if (acc_clear) begin
            sum <= '0;
        end else if (acc_en) begin
            sum <= sum + term;
        end
    end

endmodule

`default_nettype wire

// File: rtl/output_stage.sv
`timescale 1ns/1ns
`default_nettype none

module output_stage
    import fft_pkg::*;
#(
    parameter int N_POINTS = N_POINTS_DEFAULT
) (
    input  wire       osc_50,
    input  wire       reset_50m,
    input  wire       bin_done,
    input  wire       last_bin,
    input  wire       inverse,
    input  wire acc_t sum_real,
    input  wire acc_t sum_imag,
    input  wire       fft_receive_command,
    output logic      result_valid,
    output logic      result_taken,
    output logic      fft_receive_response,
    output sample_t   fft_data_real_out,
    output sample_t   fft_data_imag_out,
    output logic      fft_data_end_out
);

    // forward results are divided by the block length
    localparam int DIV_SHIFT = $clog2(N_POINTS);

    acc_t real_scaled;
    acc_t imag_scaled;

    always_comb begin
        if (inverse) begin
            real_scaled = sum_real >>> TWIDDLE_FRAC;
            imag_scaled = sum_imag >>> TWIDDLE_FRAC;
        end else begin
            real_scaled = sum_real >>> (TWIDDLE_FRAC + DIV_SHIFT);
            imag_scaled = sum_imag >>> (TWIDDLE_FRAC + DIV_SHIFT);
        end
    end

    // held stable until the next bin is done
    always_ff @(posedge osc_50) begin
        if (bin_done) begin
            fft_data_real_out <= sample_t'(real_scaled);
            fft_data_imag_out <= sample_t'(imag_scaled);
        end
    end

    always_ff @(posedge osc_50) begin
        if (reset_50m) begin
            result_valid         <= 1'b0;
            result_taken         <= 1'b0;
            fft_receive_response <= 1'b0;
            fft_data_end_out     <= 1'b0;
        end else begin
            result_taken <= 1'b0;
            if (bin_done) begin
                result_valid     <= 1'b1;
                fft_data_end_out <= last_bin;
            end else if (fft_receive_response && !fft_receive_command) begin
                // processor let go, the bin is consumed
                fft_receive_response <= 1'b0;
                result_taken         <= 1'b1;
                result_valid         <= 1'b0;
            end else if (result_valid && fft_receive_command) begin
                fft_receive_response <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/fft.sv
`timescale 1ns/1ns
`default_nettype none

module fft
    import fft_pkg::*;
#(
    parameter int N_POINTS = N_POINTS_DEFAULT
) (
    input  wire          osc_50,
    input  wire          reset_50m,
    input  wire          fft_send_command,
    input  wire          fft_inverse_in,
    input  wire sample_t fft_data_real_in,
    input  wire sample_t fft_data_imag_in,
    input  wire          fft_data_end_in,
    input  wire          fft_receive_command,
    output logic         fft_send_response,
    output logic         fft_receive_response,
    output sample_t      fft_data_real_out,
    output sample_t      fft_data_imag_out,
    output logic         fft_data_end_out
);

    logic        block_ready;
    logic        inverse;
    sample_t     rd_real;
    sample_t     rd_imag;
    sample_idx_t rd_index;
    sample_idx_t twiddle_index;
    logic        acc_clear;
    logic        acc_en;
    logic        bin_done;
    logic        last_bin;
    logic        block_done;
    acc_t        sum_real;
    acc_t        sum_imag;
    logic        result_valid;
    logic        result_taken;

    sample_buffer #(.N_POINTS(N_POINTS)) u_sample_buffer (
        .osc_50            (osc_50),
        .reset_50m         (reset_50m),
        .fft_send_command  (fft_send_command),
        .fft_inverse_in    (fft_inverse_in),
        .fft_data_real_in  (fft_data_real_in),
        .fft_data_imag_in  (fft_data_imag_in),
        .fft_data_end_in   (fft_data_end_in),
        .rd_index          (rd_index),
        .result_valid      (result_valid),
        .block_done        (block_done),
        .fft_send_response (fft_send_response),
        .block_ready       (block_ready),
        .inverse           (inverse),
        .rd_real           (rd_real),
        .rd_imag           (rd_imag)
    );

    transform_control #(.N_POINTS(N_POINTS)) u_transform_control (
        .osc_50        (osc_50),
        .reset_50m     (reset_50m),
        .block_ready   (block_ready),
        .result_taken  (result_taken),
        .rd_index      (rd_index),
        .twiddle_index (twiddle_index),
        .acc_clear     (acc_clear),
        .acc_en        (acc_en),
        .bin_done      (bin_done),
        .last_bin      (last_bin),
        .block_done    (block_done)
    );

    dft_accumulator #(.N_POINTS(N_POINTS), .IMAG_PART(0)) acc_real (
        .osc_50        (osc_50),
        .acc_clear     (acc_clear),
        .acc_en        (acc_en),
        .inverse       (inverse),
        .twiddle_index (twiddle_index),
        .sample_real   (rd_real),
        .sample_imag   (rd_imag),
        .sum           (sum_real)
    );

    dft_accumulator #(.N_POINTS(N_POINTS), .IMAG_PART(1)) acc_imag (
        .osc_50        (osc_50),
        .acc_clear     (acc_clear),
        .acc_en        (acc_en),
        .inverse       (inverse),
        .twiddle_index (twiddle_index),
        .sample_real   (rd_real),
        .sample_imag   (rd_imag),
        .sum           (sum_imag)
    );

    output_stage #(.N_POINTS(N_POINTS)) u_output_stage (
        .osc_50               (osc_50),
        .reset_50m            (reset_50m),
        .bin_done             (bin_done),
        .last_bin             (last_bin),
        .inverse              (inverse),
        .sum_real             (sum_real),
        .sum_imag             (sum_imag),
        .fft_receive_command  (fft_receive_command),
        .result_valid         (result_valid),
        .result_taken         (result_taken),
        .fft_receive_response (fft_receive_response),
        .fft_data_real_out    (fft_data_real_out),
        .fft_data_imag_out    (fft_data_imag_out),
        .fft_data_end_out     (fft_data_end_out)
    );

endmodule

`default_nettype wire

// File: tests/fft_properties.sv
`timescale 1ns/1ns
`default_nettype none

// handshake checks, bound once per four-phase port
module fft_properties (
    input wire osc_50,
    input wire reset_50m,
    input wire command,
    input wire response,
    input wire valid,
    input wire hold
);

    response_low_after_reset: assert property (
        @(posedge osc_50) $past(reset_50m) |-> !response
    ) else $error("response is high right after reset");

    // while hold is high a response may only rise with a result held
    rise_needs_result: assert property (
        @(posedge osc_50) disable iff (reset_50m)
        $rose(response) |-> (valid || !hold)
    ) else $error("response rose without a result held");

    fall_follows_command: assert property (
        @(posedge osc_50) disable iff (reset_50m)
        $fell(command) |=> !response
    ) else $error("response did not fall one cycle after its command");

endmodule

bind output_stage fft_properties receive_checks (
    .osc_50    (osc_50),
    .reset_50m (reset_50m),
    .command   (fft_receive_command),
    .response  (fft_receive_response),
    .valid     (result_valid),
    .hold      (1'b1)
);

// final write ack is held back while block_ready is high
bind sample_buffer fft_properties send_checks (
    .osc_50    (osc_50),
    .reset_50m (reset_50m),
    .command   (fft_send_command),
    .response  (fft_send_response),
    .valid     (result_valid),
    .hold      (block_ready)
);

`default_nettype wire

// File: tests/fft_tb.sv
`timescale 1ns/1ns
`default_nettype none

module fft_tb;

    localparam int N_POINTS         = 8;
    localparam int BLOCK_WORDS      = 2 + 4 * N_POINTS;
    localparam int MAX_WORDS        = 256;
    localparam int CYCLES_PER_BLOCK = 400;

    logic        osc_50;
    logic        reset_50m;
    logic        fft_send_command;
    logic        fft_inverse_in;
    logic [15:0] fft_data_real_in;
    logic [15:0] fft_data_imag_in;
    logic        fft_data_end_in;
    logic        fft_receive_command;
    logic        fft_send_response;
    logic        fft_receive_response;
    logic [15:0] fft_data_real_out;
    logic [15:0] fft_data_imag_out;
    logic        fft_data_end_out;

    logic [15:0] testdata [MAX_WORDS];
    int          n_blocks;
    int          bins_read;
    int          errors;
    logic [31:0] send_rng;
    logic [31:0] recv_rng;

    fft dut (
        .osc_50               (osc_50),
        .reset_50m            (reset_50m),
        .fft_send_command     (fft_send_command),
        .fft_inverse_in       (fft_inverse_in),
        .fft_data_real_in     (fft_data_real_in),
        .fft_data_imag_in     (fft_data_imag_in),
        .fft_data_end_in      (fft_data_end_in),
        .fft_receive_command  (fft_receive_command),
        .fft_send_response    (fft_send_response),
        .fft_receive_response (fft_receive_response),
        .fft_data_real_out    (fft_data_real_out),
        .fft_data_imag_out    (fft_data_imag_out),
        .fft_data_end_out     (fft_data_end_out)
    );

    initial begin
        osc_50 = 1'b0;
        forever #20 osc_50 = ~osc_50;
    end

    function automatic logic [31:0] next_random(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(input string what, input logic [15:0] actual,
                               input logic [15:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %0t ns %s: got %h, expected %h", $time, what, actual, expected);
            $display("Result: FAILED");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic send_sample(input int b, input int n, input int count, input logic inv,
                               input logic [15:0] re, input logic [15:0] im);
        logic last;
        last = (n == count - 1);
        send_rng = next_random(send_rng);
        repeat (send_rng[1:0]) @(posedge osc_50);
        @(posedge osc_50);
        fft_send_command <= 1'b1;
        fft_inverse_in   <= inv;
        fft_data_real_in <= re;
        fft_data_imag_in <= im;
        fft_data_end_in  <= last && (count < N_POINTS);
        @(negedge osc_50);
        while (!fft_send_response) @(negedge osc_50);
        // a new block is only acked once the previous one is fully read
        if (n == 0) begin
            check_value($sformatf("block %0d acked before readout ended", b),
                        16'(bins_read >= N_POINTS * b), 16'd1);
        end
        if (last) begin
            check_value($sformatf("block %0d final ack before first result", b),
                        {15'd0, dut.result_valid}, 16'd1);
        end
        send_rng = next_random(send_rng);
        repeat (send_rng[1:0]) @(posedge osc_50);
        @(posedge osc_50);
        fft_send_command <= 1'b0;
        @(negedge osc_50);
        while (fft_send_response) @(negedge osc_50);
    endtask

    task automatic receive_bin(input int b, input int k, input logic [15:0] exp_re,
                               input logic [15:0] exp_im);
        recv_rng = next_random(recv_rng);
        repeat (recv_rng[1:0]) @(posedge osc_50);
        @(posedge osc_50);
        fft_receive_command <= 1'b1;
        @(negedge osc_50);
        while (!fft_receive_response) @(negedge osc_50);
        check_value($sformatf("block %0d bin %0d real", b, k), fft_data_real_out, exp_re);
        check_value($sformatf("block %0d bin %0d imag", b, k), fft_data_imag_out, exp_im);
        check_value($sformatf("block %0d bin %0d end flag", b, k),
                    {15'd0, fft_data_end_out}, 16'(k == N_POINTS - 1));
        recv_rng = next_random(recv_rng);
        repeat (recv_rng[1:0]) @(posedge osc_50);
        @(posedge osc_50);
        fft_receive_command <= 1'b0;
        @(negedge osc_50);
        while (fft_receive_response) @(negedge osc_50);
        bins_read++;
    endtask

    task automatic send_blocks();
        int base;
        int count;
        for (int b = 0; b < n_blocks; b++) begin
            base  = 1 + b * BLOCK_WORDS;
            count = int'(testdata[base + 1]);
            for (int n = 0; n < count; n++) begin
                send_sample(b, n, count, testdata[base][0],
                            testdata[base + 2 + 2 * n], testdata[base + 3 + 2 * n]);
            end
        end
    endtask

    task automatic receive_blocks();
        int base;
        for (int b = 0; b < n_blocks; b++) begin
            // expected pairs follow the eight input pairs
            base = 1 + b * BLOCK_WORDS + 2 + 2 * N_POINTS;
            for (int k = 0; k < N_POINTS; k++) begin
                receive_bin(b, k, testdata[base + 2 * k], testdata[base + 1 + 2 * k]);
            end
        end
    endtask

    initial begin
        reset_50m           = 1'b1;
        fft_send_command    = 1'b0;
        fft_inverse_in      = 1'b0;
        fft_data_real_in    = '0;
        fft_data_imag_in    = '0;
        fft_data_end_in     = 1'b0;
        fft_receive_command = 1'b0;
        errors              = 0;
        bins_read           = 0;
        send_rng            = 32'h1d04;
        recv_rng            = next_random(32'h1d04);
        $readmemh("tests/fft_testdata.txt", testdata);
        n_blocks = int'(testdata[0]);
        if (n_blocks < 1 || n_blocks > (MAX_WORDS - 1) / BLOCK_WORDS) begin
            $display("the test data file does not give a usable block count");
            $display("Result: FAILED");
            $fatal(1, "bad test data");
        end
        repeat (3) @(posedge osc_50);
        reset_50m <= 1'b0;
        fork
            send_blocks();
            receive_blocks();
        join
        repeat (4) @(posedge osc_50);
        if (errors == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            $display("Result: FAILED");
            $fatal(1, "checks failed");
        end
    end

    // watchdog, budget scales with the number of blocks
    initial begin
        @(negedge reset_50m);
        repeat (n_blocks * CYCLES_PER_BLOCK) @(posedge osc_50);
        $display("the run timed out after %0d cycles", n_blocks * CYCLES_PER_BLOCK);
        $display("Result: FAILED");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

// File: fft.f
rtl/fft_pkg.sv
rtl/sample_buffer.sv
rtl/transform_control.sv
rtl/dft_accumulator.sv
rtl/output_stage.sv
rtl/fft.sv
tests/fft_properties.sv
tests/fft_tb.sv

// File: Makefile
# Verilator build and run of the fft testbench

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f fft.f --top-module fft_tb \
		-Mdir obj_dir -o Vfft_tb

run: compile
	./obj_dir/Vfft_tb

clean:
	rm -rf obj_dir

// File: tests/fft_testdata.txt
// first word is the block count; each block is: inverse flag, sample count,
// eight input pairs (real imag), then eight expected output pairs (real imag)
0003
// full forward block, samples at even indices only
0000 0008
0640 0000 0000 0000 0320 0190 0000 0000 FE70 0320 0000 0000 0000 F9C0 0000 0000
00FA FFCE 01F4 FF38 0032 00FA 0000 0000 00FA FFCE 01F4 FF38 0032 00FA 0000 0000
// short forward block of three samples, zero padded
0000 0003
0400 0000 0800 0000 0000 0200 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0180 0040 0175 FF4A 0080 FEC0 FF8A FF4A FF80 0040 000A 00B5 0080 00C0 00F5 00B5
// inverse of the first block's result, gives back the first block's samples
0001 0008
00FA FFCE 01F4 FF38 0032 00FA 0000 0000 00FA FFCE 01F4 FF38 0032 00FA 0000 0000
0640 0000 0000 0000 0320 0190 0000 0000 FE70 0320 0000 0000 0000 F9C0 0000 0000
